// ==== mrc.f ====
verilog/mrc_pkg.sv
verilog/mrc_if.sv
verilog/mrc_desc_fifo.sv
verilog/mrc_desc_fsm.sv
verilog/mrc_storage_mem.sv
verilog/mrc_req_out.sv
verilog/mrc_top.sv
test/mrc_properties.sv
test/mrc_tb.sv

// ==== test/mrc_tb.sv ====
// testbench for the memory read controller, table driven with a request scoreboard
`default_nettype none

module mrc_tb;

  localparam int period    = 4;
  localparam int num_rows  = 7;
  localparam int passes    = 2;
  // cycles allowed per descriptor, back-pressure included
  localparam int row_bound = 200;
  localparam int timeout   = (64 + 20 + (passes * num_rows + 1) * row_bound) * period;

  localparam mrc_pkg::cntl_t     c_som   = mrc_pkg::cntl_som;
  localparam mrc_pkg::cntl_t     c_mom   = mrc_pkg::cntl_mom;
  localparam mrc_pkg::cntl_t     c_eom   = mrc_pkg::cntl_eom;
  localparam mrc_pkg::opt_type_t t_none  = 8'd0;
  localparam mrc_pkg::opt_type_t t_lanes = mrc_pkg::opt_type_num_lanes;
  localparam mrc_pkg::opt_type_t t_mem   = mrc_pkg::opt_type_memory;
  localparam mrc_pkg::opt_type_t t_tgt   = mrc_pkg::opt_type_target;
  localparam mrc_pkg::opt_type_t t_txf   = mrc_pkg::opt_type_txfer;

  typedef struct packed {
    logic [1:0]          nbeats;
    logic [0:2][49:0]    beat;
    mrc_pkg::num_lanes_t lanes;
    logic                target;
    logic                txfer;
    mrc_pkg::sd_addr_t   sd;
    logic                err;
  } row_t;

  typedef struct packed {
    mrc_pkg::cntl_t      cntl;
    mrc_pkg::dram_addr_t base;
    mrc_pkg::cons_jump_t cj;
    mrc_pkg::num_lanes_t lanes;
    logic                target;
    logic                txfer;
  } req_t;

  // ----------------------------------------
  // descriptor table
  // ----------------------------------------
  // beat is cntl, then type and value of tuples 0, 1 and 2
  localparam row_t rows [num_rows] = '{
    // all four option types over three beats
    '{2'd3, '{{c_som, t_lanes, 8'd8, t_tgt, 8'h03, t_txf, 8'd1},
              {c_mom, t_none, 8'd0, t_none, 8'd0, t_none, 8'd0},
              {c_eom, t_mem, 8'h12, t_none, 8'h04, t_none, 8'd0}},
      6'd8, 1'b1, 1'b1, 4'd4, 1'b0},
    // single entry walk
    '{2'd2, '{{c_som, t_mem, 8'h00, t_none, 8'h03, t_lanes, 8'd32},
              {c_eom, t_txf, 8'd1, t_none, 8'd0, t_none, 8'd0}, 50'd0},
      6'd32, 1'b0, 1'b1, 4'd3, 1'b0},
    // memory pointer starting in tuple 1
    '{2'd2, '{{c_som, t_tgt, 8'd1, t_mem, 8'h7f, t_none, 8'h01},
              {c_eom, t_lanes, 8'd3, t_none, 8'd0, t_none, 8'd0}, 50'd0},
      6'd3, 1'b1, 1'b0, 4'd1, 1'b0},
    // repeats inside a beat and across beats
    '{2'd3, '{{c_som, t_lanes, 8'd5, t_lanes, 8'd9, t_tgt, 8'd1},
              {c_mom, t_txf, 8'd1, t_txf, 8'd0, t_none, 8'd0},
              {c_eom, t_lanes, 8'd12, t_mem, 8'h00, t_none, 8'h0a}},
      6'd12, 1'b1, 1'b1, 4'd10, 1'b0},
    // no options at all
    '{2'd2, '{{c_som, 48'd0}, {c_eom, 48'd0}, 50'd0}, 6'd0, 1'b0, 1'b0, 4'd0, 1'b0},
    // memory type in tuple 2 is not a pointer
    '{2'd2, '{{c_som, t_lanes, 8'd16, t_txf, 8'h02, t_mem, 8'h05},
              {c_eom, t_mem, 8'h00, t_none, 8'h0e, t_tgt, 8'd1}, 50'd0},
      6'd16, 1'b1, 1'b0, 4'd14, 1'b0},
    // bad first beat, runs last
    '{2'd2, '{{c_mom, t_lanes, 8'd7, t_none, 8'd0, t_none, 8'd0}, {c_eom, 48'd0}, 50'd0},
      6'd0, 1'b0, 1'b0, 4'd0, 1'b1}
  };

  logic                clk;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  mrc_pkg::cntl_t      in_cntl;
  mrc_pkg::opt_type_t  in_opt_type  [mrc_pkg::opt_per_inst];
  mrc_pkg::opt_value_t in_opt_value [mrc_pkg::opt_per_inst];
  logic                sd_wr_en;
  mrc_pkg::sd_addr_t   sd_wr_addr;
  mrc_pkg::dram_addr_t sd_wr_base;
  mrc_pkg::cj_addr_t   sd_wr_cj_ptr;
  logic                cj_wr_en;
  mrc_pkg::cj_addr_t   cj_wr_addr;
  mrc_pkg::cntl_t      cj_wr_cntl;
  mrc_pkg::cons_jump_t cj_wr_field;
  logic                out_valid;
  logic                out_ready;
  mrc_pkg::cntl_t      out_cntl;
  mrc_pkg::dram_addr_t out_base_addr;
  mrc_pkg::cons_jump_t out_cons_jump;
  mrc_pkg::num_lanes_t out_num_lanes;
  logic                out_target;
  logic                out_txfer;
  logic                error;

  // testbench copy of the storage memories
  mrc_pkg::dram_addr_t sd_base_ref  [mrc_pkg::sd_depth];
  mrc_pkg::cj_addr_t   sd_ptr_ref   [mrc_pkg::sd_depth];
  mrc_pkg::cntl_t      cj_cntl_ref  [mrc_pkg::cj_depth];
  mrc_pkg::cons_jump_t cj_field_ref [mrc_pkg::cj_depth];

  req_t exp_q [$];
  req_t head;
  int   req_count;

  mrc_top u_mrc_top (
    .clk (clk), .rst (rst),
    .in_valid (in_valid), .in_ready (in_ready), .in_cntl (in_cntl),
    .in_opt_type (in_opt_type), .in_opt_value (in_opt_value),
    .sd_wr_en (sd_wr_en), .sd_wr_addr (sd_wr_addr), .sd_wr_base (sd_wr_base),
    .sd_wr_cj_ptr (sd_wr_cj_ptr), .cj_wr_en (cj_wr_en), .cj_wr_addr (cj_wr_addr),
    .cj_wr_cntl (cj_wr_cntl), .cj_wr_field (cj_wr_field),
    .out_valid (out_valid), .out_ready (out_ready), .out_cntl (out_cntl),
    .out_base_addr (out_base_addr), .out_cons_jump (out_cons_jump),
    .out_num_lanes (out_num_lanes), .out_target (out_target), .out_txfer (out_txfer),
    .error (error)
  );

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value check failed");
    end
  endtask

  // ----------------------------------------
  // memory contents and expected requests
  // ----------------------------------------
  // walks end on every address with low bits 3
  task automatic fill_tables();
    for (int a = 0; a < mrc_pkg::sd_depth; a++)
    begin
      sd_base_ref[a] = 32'h4000_0000 + a * 32'h0001_1010;
      sd_ptr_ref[a]  = mrc_pkg::cj_addr_t'(a * 4 + a % 4);
    end
    for (int a = 0; a < mrc_pkg::cj_depth; a++)
    begin
      cj_field_ref[a] = {4'hc, 6'(a), 6'(a) ^ 6'h2a};
      if (a % 4 == 3)
        cj_cntl_ref[a] = c_eom;
      else if (a % 4 == 0)
        cj_cntl_ref[a] = c_som;
      else
        cj_cntl_ref[a] = c_mom;
    end
  endtask

  task automatic load_memories();
    for (int a = 0; a < mrc_pkg::cj_depth; a++)
    begin
      sd_wr_en     = (a < mrc_pkg::sd_depth);
      sd_wr_addr   = mrc_pkg::sd_addr_t'(a);
      sd_wr_base   = sd_base_ref[a % mrc_pkg::sd_depth];
      sd_wr_cj_ptr = sd_ptr_ref[a % mrc_pkg::sd_depth];
      cj_wr_en     = 1'b1;
      cj_wr_addr   = mrc_pkg::cj_addr_t'(a);
      cj_wr_cntl   = cj_cntl_ref[a];
      cj_wr_field  = cj_field_ref[a];
      @(posedge clk);
      #1;
    end
    sd_wr_en = 1'b0;
    cj_wr_en = 1'b0;
  endtask

  task automatic push_expected(input row_t r);
    req_t              e;
    mrc_pkg::cj_addr_t p;
    logic              first;
    logic              last;
    p     = sd_ptr_ref[r.sd];
    first = 1'b1;
    last  = 1'b0;
    while (!last)
    begin
      last = (cj_cntl_ref[p] == c_eom) || (cj_cntl_ref[p] == mrc_pkg::cntl_som_eom);
      if (first)
        e.cntl = last ? mrc_pkg::cntl_som_eom : c_som;
      else
        e.cntl = last ? c_eom : c_mom;
      e.base   = sd_base_ref[r.sd];
      e.cj     = cj_field_ref[p];
      e.lanes  = r.lanes;
      e.target = r.target;
      e.txfer  = r.txfer;
      exp_q.push_back(e);
      p     = p + 1'b1;
      first = 1'b0;
    end
  endtask

  // upstream stops as soon as in_ready is seen low
  task automatic send_beat(input logic [49:0] b);
    while (!in_ready)
    begin
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_cntl  = b[49:48];
    for (int i = 0; i < mrc_pkg::opt_per_inst; i++)
    begin
      in_opt_type[i]  = b[47 - 16 * i -: 8];
      in_opt_value[i] = b[39 - 16 * i -: 8];
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_row(input row_t r);
    for (int k = 0; k < r.nbeats; k++)
      send_beat(r.beat[k]);
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // ----------------------------------------
  // downstream side
  // ----------------------------------------
  // random out_ready back-pressure
  initial
  begin
    void'($urandom(94));
    forever
    begin
      @(posedge clk);
      #1;
      out_ready = ($urandom % 4) != 0;
    end
  end

  always @(posedge clk)
  begin
    if (!rst && out_valid && out_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("read request at %0t arrived with nothing expected", $time);
        $display("Regression failed");
        $fatal(1, "unexpected request");
      end
      else
      begin
        head = exp_q.pop_front();
        check_value($sformatf("req %0d cntl", req_count), out_cntl, head.cntl);
        check_value($sformatf("req %0d base", req_count), out_base_addr, head.base);
        check_value($sformatf("req %0d cons_jump", req_count), out_cons_jump, head.cj);
        check_value($sformatf("req %0d lanes", req_count), out_num_lanes, head.lanes);
        check_value($sformatf("req %0d target", req_count), out_target, head.target);
        check_value($sformatf("req %0d txfer", req_count), out_txfer, head.txfer);
        req_count++;
      end
    end
  end

  // stop at the first failed output assertion
  always @(posedge clk)
  begin
    if (u_mrc_top.u_req_out.u_props.fail_count != 0)
    begin
      $display("request output assertion failed before %0t", $time);
      $display("Regression failed");
      $fatal(1, "assertion failure");
    end
  end

  initial
  begin
    #(timeout);
    $display("TIMEOUT: run did not finish within %0d time units", timeout);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_cntl   = '0;
    in_opt_type  = '{default: '0};
    in_opt_value = '{default: '0};
    sd_wr_en  = 1'b0;
    sd_wr_addr   = '0;
    sd_wr_base   = '0;
    sd_wr_cj_ptr = '0;
    cj_wr_en  = 1'b0;
    cj_wr_addr   = '0;
    cj_wr_cntl   = '0;
    cj_wr_field  = '0;
    out_ready = 1'b0;
    req_count = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fill_tables();
    load_memories();
    // good descriptors back to back
    for (int n = 0; n < passes; n++)
      for (int r = 0; r < num_rows; r++)
        if (!rows[r].err)
        begin
          push_expected(rows[r]);
          send_row(rows[r]);
        end
    wait_drained();
    for (int r = 0; r < num_rows; r++)
      if (rows[r].err)
        send_row(rows[r]);
    while (!error)
    begin
      @(posedge clk);
      #1;
    end
    repeat (10)
    begin
      @(posedge clk);
      #1;
    end
    check_value("sticky error", error, 1'b1);
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("error after reset", error, 1'b0);
    check_value("out_valid after reset", out_valid, 1'b0);
    check_value("in_ready after reset", in_ready, 1'b0);
    @(posedge clk);
    #1;
    check_value("in_ready one cycle after reset", in_ready, 1'b1);
    if (u_mrc_top.u_req_out.u_props.fail_count != 0)
    begin
      $display("request output assertions failed during the run");
      $display("Regression failed");
      $fatal(1, "assertion failures");
    end
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/mrc_properties.sv ====
// request output assertions for reset state and data held under back-pressure
`default_nettype none

module mrc_properties (
  input logic                clk,
  input logic                rst,
  input logic                out_valid,
  input logic                out_ready,
  input mrc_pkg::cntl_t      out_cntl,
  input mrc_pkg::dram_addr_t out_base_addr,
  input mrc_pkg::cons_jump_t out_cons_jump,
  input mrc_pkg::num_lanes_t out_num_lanes,
  input logic                out_target,
  input logic                out_txfer
);

  int fail_count = 0;

  // whole request beat as one word
  logic [57:0] out_word;
  assign out_word = {out_cntl, out_base_addr, out_cons_jump, out_num_lanes, out_target, out_txfer};

  valid_low_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else
    begin
      fail_count++;
      $error("out_valid high in the cycle after reset");
    end

  valid_held: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid)
    else
    begin
      fail_count++;
      $error("out_valid dropped before out_ready");
    end

  data_held: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_word))
    else
    begin
      fail_count++;
      $error("request data changed while stalled");
    end

endmodule

bind mrc_req_out mrc_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .out_valid     (out_valid),
  .out_ready     (out_ready),
  .out_cntl      (out_cntl),
  .out_base_addr (out_base_addr),
  .out_cons_jump (out_cons_jump),
  .out_num_lanes (out_num_lanes),
  .out_target    (out_target),
  .out_txfer     (out_txfer)
);

`default_nettype wire

// ==== verilog/mrc_top.sv ====
// memory read controller top level joining input FIFO, FSM, storage memories and output
`default_nettype none

module mrc_top (
  input  logic                clk,
  input  logic                rst,
  // descriptor beats from upstream
  input  logic                in_valid,
  output logic                in_ready,
  input  mrc_pkg::cntl_t      in_cntl,
  input  mrc_pkg::opt_type_t  in_opt_type  [mrc_pkg::opt_per_inst],
  input  mrc_pkg::opt_value_t in_opt_value [mrc_pkg::opt_per_inst],
  // memory load port, used while idle
  input  logic                sd_wr_en,
  input  mrc_pkg::sd_addr_t   sd_wr_addr,
  input  mrc_pkg::dram_addr_t sd_wr_base,
  input  mrc_pkg::cj_addr_t   sd_wr_cj_ptr,
  input  logic                cj_wr_en,
  input  mrc_pkg::cj_addr_t   cj_wr_addr,
  input  mrc_pkg::cntl_t      cj_wr_cntl,
  input  mrc_pkg::cons_jump_t cj_wr_field,
  // read requests to downstream
  output logic                out_valid,
  input  logic                out_ready,
  output mrc_pkg::cntl_t      out_cntl,
  output mrc_pkg::dram_addr_t out_base_addr,
  output mrc_pkg::cons_jump_t out_cons_jump,
  output mrc_pkg::num_lanes_t out_num_lanes,
  output logic                out_target,
  output logic                out_txfer,
  output logic                error
);

  desc_if desc_bus ();
  req_if  req_bus ();

  mrc_pkg::sd_addr_t   sd_rd_addr;
  mrc_pkg::dram_addr_t sd_base;
  mrc_pkg::cj_addr_t   sd_cj_ptr;
  mrc_pkg::cj_addr_t   cj_rd_addr;
  mrc_pkg::cntl_t      cj_cntl;
  mrc_pkg::cons_jump_t cj_field;

  // ----------------------------------------
  // datapath blocks
  // ----------------------------------------
  mrc_desc_fifo u_desc_fifo (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_cntl      (in_cntl),
    .in_opt_type  (in_opt_type),
    .in_opt_value (in_opt_value),
    .in_ready     (in_ready),
    .desc         (desc_bus.src)
  );

  mrc_desc_fsm u_desc_fsm (
    .clk        (clk),
    .rst        (rst),
    .desc       (desc_bus.dst),
    .req        (req_bus.src),
    .sd_rd_addr (sd_rd_addr),
    .sd_base    (sd_base),
    .sd_cj_ptr  (sd_cj_ptr),
    .cj_rd_addr (cj_rd_addr),
    .cj_cntl    (cj_cntl),
    .cj_field   (cj_field),
    .error      (error)
  );

  mrc_storage_mem u_storage_mem (
    .clk          (clk),
    .sd_wr_en     (sd_wr_en),
    .sd_wr_addr   (sd_wr_addr),
    .sd_wr_base   (sd_wr_base),
    .sd_wr_cj_ptr (sd_wr_cj_ptr),
    .cj_wr_en     (cj_wr_en),
    .cj_wr_addr   (cj_wr_addr),
    .cj_wr_cntl   (cj_wr_cntl),
    .cj_wr_field  (cj_wr_field),
    .sd_rd_addr   (sd_rd_addr),
    .sd_base      (sd_base),
    .sd_cj_ptr    (sd_cj_ptr),
    .cj_rd_addr   (cj_rd_addr),
    .cj_cntl      (cj_cntl),
    .cj_field     (cj_field)
  );

  mrc_req_out u_req_out (
    .clk           (clk),
    .rst           (rst),
    .req           (req_bus.dst),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_cntl      (out_cntl),
    .out_base_addr (out_base_addr),
    .out_cons_jump (out_cons_jump),
    .out_num_lanes (out_num_lanes),
    .out_target    (out_target),
    .out_txfer     (out_txfer)
  );

endmodule

`default_nettype wire

// ==== verilog/mrc_req_out.sv ====
// read request output side, a two entry skid register on the downstream handshake
`default_nettype none

module mrc_req_out (
  input  logic                clk,
  input  logic                rst,
  req_if.dst                  req,
  output logic                out_valid,
  input  logic                out_ready,
  output mrc_pkg::cntl_t      out_cntl,
  output mrc_pkg::dram_addr_t out_base_addr,
  output mrc_pkg::cons_jump_t out_cons_jump,
  output mrc_pkg::num_lanes_t out_num_lanes,
  output logic                out_target,
  output logic                out_txfer
);

  logic                skid_valid;
  mrc_pkg::cntl_t      skid_cntl;
  mrc_pkg::dram_addr_t skid_base_addr;
  mrc_pkg::cons_jump_t skid_cons_jump;
  mrc_pkg::num_lanes_t skid_num_lanes;
  logic                skid_target;
  logic                skid_txfer;
  logic                load_out;

  // output register can take a new beat
  assign load_out  = out_ready || !out_valid;
  assign req.ready = !skid_valid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (load_out)
    begin
      out_valid  <= skid_valid || req.valid;
      skid_valid <= 1'b0;
    end
    else if (req.valid && req.ready)
      skid_valid <= 1'b1;
  end

  // skid follows the bus while empty
  always_ff @(posedge clk)
  begin
    if (req.ready)
    begin
      skid_cntl      <= req.cntl;
      skid_base_addr <= req.base_addr;
      skid_cons_jump <= req.cons_jump;
      skid_num_lanes <= req.num_lanes;
      skid_target    <= req.target;
      skid_txfer     <= req.txfer;
    end
    if (load_out && skid_valid)
    begin
      out_cntl      <= skid_cntl;
      out_base_addr <= skid_base_addr;
      out_cons_jump <= skid_cons_jump;
      out_num_lanes <= skid_num_lanes;
      out_target    <= skid_target;
      out_txfer     <= skid_txfer;
    end
    else if (load_out)
    begin
      out_cntl      <= req.cntl;
      out_base_addr <= req.base_addr;
      out_cons_jump <= req.cons_jump;
      out_num_lanes <= req.num_lanes;
      out_target    <= req.target;
      out_txfer     <= req.txfer;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mrc_storage_mem.sv ====
// storage descriptor and cons/jump memories with write ports and registered reads
`default_nettype none

module mrc_storage_mem (
  input  logic                clk,
  input  logic                sd_wr_en,
  input  mrc_pkg::sd_addr_t   sd_wr_addr,
  input  mrc_pkg::dram_addr_t sd_wr_base,
  input  mrc_pkg::cj_addr_t   sd_wr_cj_ptr,
  input  logic                cj_wr_en,
  input  mrc_pkg::cj_addr_t   cj_wr_addr,
  input  mrc_pkg::cntl_t      cj_wr_cntl,
  input  mrc_pkg::cons_jump_t cj_wr_field,
  input  mrc_pkg::sd_addr_t   sd_rd_addr,
  output mrc_pkg::dram_addr_t sd_base,
  output mrc_pkg::cj_addr_t   sd_cj_ptr,
  input  mrc_pkg::cj_addr_t   cj_rd_addr,
  output mrc_pkg::cntl_t      cj_cntl,
  output mrc_pkg::cons_jump_t cj_field
);

  // storage descriptor: main memory base and cons/jump pointer
  mrc_pkg::dram_addr_t sd_base_mem   [mrc_pkg::sd_depth];
  mrc_pkg::cj_addr_t   sd_cj_ptr_mem [mrc_pkg::sd_depth];

  // cons/jump entries, delimited by their control code
  mrc_pkg::cntl_t      cj_cntl_mem  [mrc_pkg::cj_depth];
  mrc_pkg::cons_jump_t cj_field_mem [mrc_pkg::cj_depth];

  // ----------------------------------------
  // storage descriptor memory
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (sd_wr_en)
    begin
      sd_base_mem[sd_wr_addr]   <= sd_wr_base;
      sd_cj_ptr_mem[sd_wr_addr] <= sd_wr_cj_ptr;
    end
    sd_base   <= sd_base_mem[sd_rd_addr];
    sd_cj_ptr <= sd_cj_ptr_mem[sd_rd_addr];
  end

  // ----------------------------------------
  // cons/jump memory
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (cj_wr_en)
    begin
      cj_cntl_mem[cj_wr_addr]  <= cj_wr_cntl;
      cj_field_mem[cj_wr_addr] <= cj_wr_field;
    end
    cj_cntl  <= cj_cntl_mem[cj_rd_addr];
    cj_field <= cj_field_mem[cj_rd_addr];
  end

endmodule

`default_nettype wire

// ==== verilog/mrc_desc_fsm.sv ====
// descriptor FSM that extracts the option fields and walks the cons/jump memory
`default_nettype none

module mrc_desc_fsm (
  input  logic                clk,
  input  logic                rst,
  desc_if.dst                 desc,
  req_if.src                  req,
  output mrc_pkg::sd_addr_t   sd_rd_addr,
  input  mrc_pkg::dram_addr_t sd_base,
  input  mrc_pkg::cj_addr_t   sd_cj_ptr,
  output mrc_pkg::cj_addr_t   cj_rd_addr,
  input  mrc_pkg::cntl_t      cj_cntl,
  input  mrc_pkg::cons_jump_t cj_field,
  output logic                error
);

  mrc_pkg::mrc_state_t state;
  mrc_pkg::mrc_state_t state_next;

  // fields gathered from the option tuples
  mrc_pkg::num_lanes_t num_lanes;
  mrc_pkg::sd_ptr_t    sd_ptr;
  logic                target;
  logic                txfer;

  mrc_pkg::cj_addr_t   cj_addr;
  logic                first_req;
  logic                take;
  logic                cj_last;

  assign desc.ready = (state == mrc_pkg::st_wait) || (state == mrc_pkg::st_extract);
  assign take       = desc.valid && desc.ready;
  assign cj_last    = (cj_cntl == mrc_pkg::cntl_eom) || (cj_cntl == mrc_pkg::cntl_som_eom);
  assign error      = (state == mrc_pkg::st_err);

  // ----------------------------------------
  // state register and transitions
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= mrc_pkg::st_wait;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      mrc_pkg::st_wait:
        if (desc.valid)
          state_next = (desc.cntl == mrc_pkg::cntl_som) ? mrc_pkg::st_extract : mrc_pkg::st_err;
      mrc_pkg::st_extract:
        if (desc.valid && (desc.cntl == mrc_pkg::cntl_eom))
          state_next = mrc_pkg::st_sd_read;
      // storage descriptor read latency
      mrc_pkg::st_sd_read:
        state_next = mrc_pkg::st_cj_read;
      mrc_pkg::st_cj_read:
        state_next = mrc_pkg::st_cj_send;
      mrc_pkg::st_cj_send:
        if (req.ready)
          state_next = cj_last ? mrc_pkg::st_complete : mrc_pkg::st_cj_read;
      mrc_pkg::st_complete:
        state_next = mrc_pkg::st_wait;
      // held until reset
      mrc_pkg::st_err:
        state_next = mrc_pkg::st_err;
      default:
        state_next = mrc_pkg::st_wait;
    endcase
  end

  // ----------------------------------------
  // option extraction
  // ----------------------------------------
  // descending loops so the lowest matching tuple lands last
  always_ff @(posedge clk)
  begin
    if (rst || (state == mrc_pkg::st_complete))
    begin
      num_lanes <= '0;
      sd_ptr    <= '0;
      target    <= 1'b0;
      txfer     <= 1'b0;
    end
    else if (take)
    begin
      for (int i = mrc_pkg::opt_per_inst - 1; i >= 0; i--)
      begin
        case (desc.opt_type[i])
          mrc_pkg::opt_type_num_lanes: num_lanes <= mrc_pkg::num_lanes_t'(desc.opt_value[i]);
          mrc_pkg::opt_type_target:    target    <= desc.opt_value[i][0];
          mrc_pkg::opt_type_txfer:     txfer     <= desc.opt_value[i][0];
          default:                     ;
        endcase
      end
      // memory pointer is an extended tuple, so only tuple 0 or 1
      for (int i = mrc_pkg::opt_per_inst - 2; i >= 0; i--)
      begin
        if (desc.opt_type[i] == mrc_pkg::opt_type_memory)
          sd_ptr <= {desc.opt_value[i], desc.opt_type[i+1], desc.opt_value[i+1]};
      end
    end
  end

  // ----------------------------------------
  // cons/jump walk
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      first_req <= 1'b1;
      cj_addr   <= '0;
    end
    else
    begin
      if (state == mrc_pkg::st_sd_read)
        first_req <= 1'b1;
      if ((state == mrc_pkg::st_cj_read) && first_req)
        cj_addr <= sd_cj_ptr;
      if ((state == mrc_pkg::st_cj_send) && req.ready)
      begin
        first_req <= 1'b0;
        cj_addr   <= cj_addr + 1'b1;
      end
    end
  end

  assign sd_rd_addr = sd_ptr[$bits(mrc_pkg::sd_addr_t)-1:0];
  // first entry is addressed straight from the storage descriptor
  assign cj_rd_addr = ((state == mrc_pkg::st_cj_read) && first_req) ? sd_cj_ptr : cj_addr;

  assign req.valid     = (state == mrc_pkg::st_cj_send);
  assign req.cntl      = first_req ? (cj_last ? mrc_pkg::cntl_som_eom : mrc_pkg::cntl_som)
                                   : (cj_last ? mrc_pkg::cntl_eom : mrc_pkg::cntl_mom);
  assign req.base_addr = sd_base;
  assign req.cons_jump = cj_field;
  assign req.num_lanes = num_lanes;
  assign req.target    = target;
  assign req.txfer     = txfer;

endmodule

`default_nettype wire

// ==== verilog/mrc_desc_fifo.sv ====
// descriptor input side: input registers, beat FIFO and a two stage output pipe
`default_nettype none

module mrc_desc_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  mrc_pkg::cntl_t      in_cntl,
  input  mrc_pkg::opt_type_t  in_opt_type  [mrc_pkg::opt_per_inst],
  input  mrc_pkg::opt_value_t in_opt_value [mrc_pkg::opt_per_inst],
  output logic                in_ready,
  desc_if.src                 desc
);

  logic                in_valid_d;
  mrc_pkg::cntl_t      in_cntl_d;
  mrc_pkg::opt_type_t  in_type_d  [mrc_pkg::opt_per_inst];
  mrc_pkg::opt_value_t in_value_d [mrc_pkg::opt_per_inst];

  mrc_pkg::cntl_t      mem_cntl  [mrc_pkg::desc_fifo_depth];
  mrc_pkg::opt_type_t  mem_type  [mrc_pkg::desc_fifo_depth][mrc_pkg::opt_per_inst];
  mrc_pkg::opt_value_t mem_value [mrc_pkg::desc_fifo_depth][mrc_pkg::opt_per_inst];

  logic [mrc_pkg::desc_fifo_ptr_w-1:0] wr_ptr;
  logic [mrc_pkg::desc_fifo_ptr_w-1:0] rd_ptr;
  logic [mrc_pkg::desc_fifo_ptr_w:0]   count;

  // FIFO output stage, ahead of the pipe stage on desc
  logic                s1_valid;
  mrc_pkg::cntl_t      s1_cntl;
  mrc_pkg::opt_type_t  s1_type  [mrc_pkg::opt_per_inst];
  mrc_pkg::opt_value_t s1_value [mrc_pkg::opt_per_inst];

  logic fifo_write;
  logic fifo_read;
  logic s1_move;
  logic pipe_move;

  assign fifo_write = in_valid_d && (count != mrc_pkg::desc_fifo_depth);
  // keep both stages charged
  assign pipe_move  = desc.valid && desc.ready;
  assign s1_move    = s1_valid && (!desc.valid || pipe_move);
  assign fifo_read  = (count != '0) && (!s1_valid || s1_move);

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      in_valid_d <= 1'b0;
      in_ready   <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      s1_valid   <= 1'b0;
      desc.valid <= 1'b0;
    end
    else
    begin
      in_valid_d <= in_valid;
      // upstream has two cycles to stop after this drops
      in_ready   <= (count < mrc_pkg::desc_fifo_threshold);
      if (fifo_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (fifo_read)
        rd_ptr <= rd_ptr + 1'b1;
      if (fifo_write && !fifo_read)
        count <= count + 1'b1;
      else if (!fifo_write && fifo_read)
        count <= count - 1'b1;
      if (fifo_read)
        s1_valid <= 1'b1;
      else if (s1_move)
        s1_valid <= 1'b0;
      if (s1_move)
        desc.valid <= 1'b1;
      else if (pipe_move)
        desc.valid <= 1'b0;
    end
  end

  // ----------------------------------------
  // beat payload
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    in_cntl_d  <= in_cntl;
    in_type_d  <= in_opt_type;
    in_value_d <= in_opt_value;
    if (fifo_write)
    begin
      mem_cntl[wr_ptr]  <= in_cntl_d;
      mem_type[wr_ptr]  <= in_type_d;
      mem_value[wr_ptr] <= in_value_d;
    end
    if (fifo_read)
    begin
      s1_cntl  <= mem_cntl[rd_ptr];
      s1_type  <= mem_type[rd_ptr];
      s1_value <= mem_value[rd_ptr];
    end
    if (s1_move)
    begin
      desc.cntl      <= s1_cntl;
      desc.opt_type  <= s1_type;
      desc.opt_value <= s1_value;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mrc_if.sv ====
// descriptor beat and read request bus interfaces of the memory read controller
`default_nettype none

// one descriptor beat with its option tuples
interface desc_if;
  logic                valid;
  logic                ready;
  mrc_pkg::cntl_t      cntl;
  mrc_pkg::opt_type_t  opt_type  [mrc_pkg::opt_per_inst];
  mrc_pkg::opt_value_t opt_value [mrc_pkg::opt_per_inst];

  modport src (
    output valid,
    output cntl,
    output opt_type,
    output opt_value,
    input  ready
  );

  modport dst (
    input  valid,
    input  cntl,
    input  opt_type,
    input  opt_value,
    output ready
  );
endinterface

// one read request beat per cons/jump entry
interface req_if;
  logic                valid;
  logic                ready;
  mrc_pkg::cntl_t      cntl;
  mrc_pkg::dram_addr_t base_addr;
  mrc_pkg::cons_jump_t cons_jump;
  mrc_pkg::num_lanes_t num_lanes;
  logic                target;
  logic                txfer;

  modport src (
    output valid,
    output cntl,
    output base_addr,
    output cons_jump,
    output num_lanes,
    output target,
    output txfer,
    input  ready
  );

  modport dst (
    input  valid,
    input  cntl,
    input  base_addr,
    input  cons_jump,
    input  num_lanes,
    input  target,
    input  txfer,
    output ready
  );
endinterface

`default_nettype wire

// ==== verilog/mrc_pkg.sv ====
// memory read controller package with widths, message codes, option types and FSM states
`default_nettype none

package mrc_pkg;

  // ----------------------------------------
  // message control codes
  // ----------------------------------------
  typedef logic [1:0] cntl_t;

  localparam cntl_t cntl_som_eom = 2'd0;
  localparam cntl_t cntl_som     = 2'd1;
  localparam cntl_t cntl_mom     = 2'd2;
  localparam cntl_t cntl_eom     = 2'd3;

  // ----------------------------------------
  // descriptor option tuples
  // ----------------------------------------
  typedef logic [7:0] opt_type_t;
  typedef logic [7:0] opt_value_t;

  localparam int opt_per_inst = 3;

  localparam opt_type_t opt_type_num_lanes = 8'd1;
  localparam opt_type_t opt_type_memory    = 8'd2;
  localparam opt_type_t opt_type_target    = 8'd3;
  localparam opt_type_t opt_type_txfer     = 8'd4;

  // extended pointer spans value, type and value of two tuples
  typedef logic [23:0] sd_ptr_t;

  // ----------------------------------------
  // storage memories and request fields
  // ----------------------------------------
  localparam int sd_depth = 16;
  localparam int cj_depth = 64;

  typedef logic [3:0]  sd_addr_t;
  typedef logic [5:0]  cj_addr_t;
  typedef logic [31:0] dram_addr_t;
  typedef logic [15:0] cons_jump_t;

  // lane count 0 to 32
  typedef logic [5:0]  num_lanes_t;

  // ----------------------------------------
  // descriptor FIFO
  // ----------------------------------------
  localparam int desc_fifo_depth     = 8;
  localparam int desc_fifo_threshold = 6;
  localparam int desc_fifo_ptr_w     = $clog2(desc_fifo_depth);

  typedef enum logic [2:0] {
    st_wait,
    st_extract,
    st_sd_read,
    st_cj_read,
    st_cj_send,
    st_complete,
    st_err
  } mrc_state_t;

endpackage

`default_nettype wire
